/* Bender.yml */
package:
  name: proxy_test

sources:
  - src/proxy_pkg.sv
  - src/reg_bus_if.sv
  - src/bus_decoder.sv
  - src/reg_proxy.sv
  - src/mem_proxy.sv
  - src/mem_ram_sp.sv
  - src/stream_pipe.sv
  - src/proxy_test_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/proxy_test_chk.sv
      - bench/tb_proxy_test.sv

/* bench/proxy_test_chk.sv */
module proxy_test_chk (
    input logic                                clk,
    input logic                                srst,
    input logic                                i_strobe,
    input logic                                i_ack,
    input logic                                i_valid,
    input logic                                i_ready,
    input logic [proxy_pkg::STREAM_DATA_WID:0] i_beat
);

    // ------------------------------------------------------------
    // Register bus
    // ------------------------------------------------------------
    ack_after_strobe: assert property (
        @(posedge clk) disable iff (srst) i_strobe |=> i_ack
    ) else $error("ack missing one cycle after a strobe");

    ack_only_after_strobe: assert property (
        @(posedge clk) disable iff (srst) i_ack |-> $past(i_strobe)
    ) else $error("ack seen without a strobe in the cycle before");

    // ------------------------------------------------------------
    // Stream output
    // ------------------------------------------------------------
    // Beat must hold while the sink stalls
    beat_held: assert property (
        @(posedge clk) disable iff (srst)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_beat))
    ) else $error("stream beat changed or dropped while not ready");

    // Outputs idle once reset has been seen
    idle_after_reset: assert property (
        @(posedge clk) srst |=> (!i_ack && !i_valid)
    ) else $error("ack or valid high after reset");

endmodule

bind bus_decoder proxy_test_chk bus_chk (
    .clk      ( clk ),
    .srst     ( srst ),
    .i_strobe ( i_wr | i_rd ),
    .i_ack    ( o_ack ),
    .i_valid  ( 1'b0 ),
    .i_ready  ( 1'b1 ),
    .i_beat   ( '0 )
);

bind stream_pipe proxy_test_chk stream_chk (
    .clk      ( clk ),
    .srst     ( srst ),
    .i_strobe ( 1'b0 ),
    .i_ack    ( 1'b0 ),
    .i_valid  ( o_tvalid ),
    .i_ready  ( i_tready ),
    .i_beat   ( {o_tlast, o_tdata} )
);

/* bench/tb_clk_gen.sv */
module tb_clk_gen (
    output logic o_clk,
    output logic o_srst
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset released on a rising edge, like any other driven input
    initial begin
        o_srst = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_srst <= 1'b0;
    end

endmodule

/* bench/tb_proxy_test.sv */
module tb_proxy_test;
    import proxy_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'h235fa197;
    localparam int ACK_WAIT_MAX  = 4;
    localparam int POLL_MAX      = 8;
    localparam int NUM_TRIG      = 8;
    localparam int NUM_MEM       = 64;
    localparam int STREAM_BEATS  = 200;
    localparam int BEAT_WAIT_MAX = 16;
    // Worst case per step, doubled
    localparam int ACCESS_CYCLES  = 3 + ACK_WAIT_MAX;
    localparam int CMD_OPS        = 5 + NUM_TRIG + 4 + 2 * NUM_MEM;
    localparam int CMD_ACCESSES   = 5 + POLL_MAX;
    localparam int MAP_ACCESSES   = 14 * 3 + 2;
    localparam int TIMEOUT_CYCLES = 2 * (8 + (CMD_OPS * CMD_ACCESSES + MAP_ACCESSES)
                                    * ACCESS_CYCLES + STREAM_BEATS * BEAT_WAIT_MAX + 16);

    logic                       clk;
    logic                       srst;
    logic                       wr;
    logic                       rd;
    logic [BUS_ADDR_WID-1:0]    addr;
    logic [BUS_DATA_WID-1:0]    wr_data;
    logic [BUS_DATA_WID-1:0]    rd_data;
    logic                       ack;
    logic [STREAM_DATA_WID-1:0] s_tdata;
    logic                       s_tvalid;
    logic                       s_tlast;
    logic                       s_tready;
    logic [STREAM_DATA_WID-1:0] m_tdata;
    logic                       m_tvalid;
    logic                       m_tlast;
    logic                       m_tready;

    logic [31:0]                lfsr_state;
    int                         err_word;
    int                         err_beat;
    int                         err_other;
    int                         cycle_cnt;

    // Reference state
    logic [BUS_DATA_WID-1:0]    ref_trigger;
    logic [BUS_DATA_WID-1:0]    ref_status;
    logic [BUS_DATA_WID-1:0]    ref_proxy_addr;
    logic [BUS_DATA_WID-1:0]    ref_mem_addr;
    logic [BUS_DATA_WID-1:0]    mem_model [MEM_DEPTH];
    logic [STREAM_DATA_WID:0]   sent_q [$];
    logic [STREAM_DATA_WID:0]   mon_beat;

    tb_clk_gen clk_gen (
        .o_clk  ( clk ),
        .o_srst ( srst )
    );

    proxy_test_top UUT (
        .clk        ( clk ),
        .srst       ( srst ),
        .i_wr       ( wr ),
        .i_rd       ( rd ),
        .i_addr     ( addr ),
        .i_wr_data  ( wr_data ),
        .o_rd_data  ( rd_data ),
        .o_ack      ( ack ),
        .i_s_tdata  ( s_tdata ),
        .i_s_tvalid ( s_tvalid ),
        .i_s_tlast  ( s_tlast ),
        .o_s_tready ( s_tready ),
        .o_m_tdata  ( m_tdata ),
        .o_m_tvalid ( m_tvalid ),
        .o_m_tlast  ( m_tlast ),
        .i_m_tready ( m_tready )
    );

    // ------------------------------------------------------------
    // Random bits, x^32 + x^22 + x^2 + x + 1
    // ------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    // Hidden register block model
    function automatic logic [BUS_DATA_WID-1:0] ind_ref_read(input logic [BUS_DATA_WID-1:0] a);
        case (a)
            32'd0:   return INFO_PRE;
            32'd1:   return INFO_POST;
            32'd2:   return ref_trigger;
            32'd3:   return ref_status;
            default: return BAD_ADDR_DATA;
        endcase
    endfunction

    function automatic void ind_ref_write(input logic [BUS_DATA_WID-1:0] a,
                                          input logic [BUS_DATA_WID-1:0] d);
        if (a == 32'd2) begin
            ref_trigger = d;
            ref_status  = d;
        end
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_word(input string name, input logic [BUS_DATA_WID-1:0] exp,
                              input logic [BUS_DATA_WID-1:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            err_word++;
        end
    endtask

    task automatic check_beat(input logic [STREAM_DATA_WID-1:0] exp_data, input logic exp_last,
                              input logic [STREAM_DATA_WID-1:0] act_data, input logic act_last);
        if (act_data !== exp_data || act_last !== exp_last) begin
            $display("ERR %0t o_m_tdata/o_m_tlast expected %h/%b actual %h/%b",
                     $time, exp_data, exp_last, act_data, act_last);
            err_beat++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
            err_other++;
        end
    endtask

    // ------------------------------------------------------------
    // Host bus access, strobe for one cycle then ack
    // ------------------------------------------------------------
    task automatic bus_access(input logic is_wr, input logic [BUS_ADDR_WID-1:0] a,
                              input logic [BUS_DATA_WID-1:0] d,
                              output logic [BUS_DATA_WID-1:0] q);
        int waited;
        waited = 0;
        @(posedge clk);
        wr      <= is_wr;
        rd      <= !is_wr;
        addr    <= a;
        wr_data <= d;
        @(posedge clk);
        wr <= 1'b0;
        rd <= 1'b0;
        @(negedge clk);
        if (!ack) begin
            $display("No ack one cycle after access to address %h at %0t", a, $time);
            err_other++;
            while (!ack && waited < ACK_WAIT_MAX) begin
                @(negedge clk);
                waited++;
            end
        end
        q = rd_data;
    endtask

    task automatic bus_write(input logic [BUS_ADDR_WID-1:0] a, input logic [BUS_DATA_WID-1:0] d);
        logic [BUS_DATA_WID-1:0] unused;
        bus_access(1'b1, a, d, unused);
    endtask

    task automatic bus_read(input logic [BUS_ADDR_WID-1:0] a, output logic [BUS_DATA_WID-1:0] q);
        bus_access(1'b0, a, '0, q);
    endtask

    task automatic poll_idle(input logic [3:0] region, input logic [7:0] status_ofs);
        logic [BUS_DATA_WID-1:0] q;
        int                      polls;
        polls = 0;
        bus_read({region, status_ofs}, q);
        while (q[STATUS_BUSY_BIT] && polls < POLL_MAX) begin
            bus_read({region, status_ofs}, q);
            polls++;
        end
        if (q[STATUS_BUSY_BIT]) begin
            $display("Busy never cleared in region %0d at %0t", region, $time);
            err_other++;
        end
    endtask

    // Indirect and memory commands
    task automatic ind_read(input logic [BUS_DATA_WID-1:0] a, output logic [BUS_DATA_WID-1:0] q);
        bus_write({REGION_REG_PROXY, PROXY_ADDR_OFS}, a);
        ref_proxy_addr = a;
        bus_write({REGION_REG_PROXY, PROXY_CMD_OFS}, '0);
        poll_idle(REGION_REG_PROXY, PROXY_STATUS_OFS);
        bus_read({REGION_REG_PROXY, PROXY_DATA_OFS}, q);
    endtask

    task automatic ind_write(input logic [BUS_DATA_WID-1:0] a, input logic [BUS_DATA_WID-1:0] d);
        bus_write({REGION_REG_PROXY, PROXY_ADDR_OFS}, a);
        ref_proxy_addr = a;
        bus_write({REGION_REG_PROXY, PROXY_DATA_OFS}, d);
        bus_write({REGION_REG_PROXY, PROXY_CMD_OFS}, 32'(1) << CMD_WRITE_BIT);
        poll_idle(REGION_REG_PROXY, PROXY_STATUS_OFS);
        ind_ref_write(a, d);
    endtask

    task automatic ind_check(input logic [BUS_DATA_WID-1:0] a);
        logic [BUS_DATA_WID-1:0] q;
        ind_read(a, q);
        check_word("PROXY_DATA", ind_ref_read(a), q);
    endtask

    task automatic mem_cmd(input logic [MEM_ADDR_WID-1:0] a, input logic is_wr,
                           input logic [BUS_DATA_WID-1:0] d, output logic [BUS_DATA_WID-1:0] q);
        bus_write({REGION_MEM_PROXY, MEM_ADDR_OFS}, 32'(a));
        ref_mem_addr = 32'(a);
        if (is_wr) begin
            bus_write({REGION_MEM_PROXY, MEM_WDATA_OFS}, d);
        end
        bus_write({REGION_MEM_PROXY, MEM_CMD_OFS}, 32'(is_wr) << CMD_WRITE_BIT);
        poll_idle(REGION_MEM_PROXY, MEM_STATUS_OFS);
        bus_read({REGION_MEM_PROXY, MEM_RDATA_OFS}, q);
    endtask

    // ------------------------------------------------------------
    // Test steps
    // ------------------------------------------------------------
    task automatic test_registers();
        logic [BUS_DATA_WID-1:0] q;
        bus_read({REGION_REG_PROXY, PROXY_STATUS_OFS}, q);
        check_word("PROXY_STATUS", '0, q);
        bus_read({REGION_MEM_PROXY, MEM_STATUS_OFS}, q);
        check_word("MEM_STATUS", '0, q);
        // Info words, reset values, then an unmapped indirect address
        for (int a = 0; a < 4; a++) begin
            ind_check(32'(a));
        end
        ind_check(32'd7);
        for (int i = 0; i < NUM_TRIG; i++) begin
            ind_write(32'(IND_TRIGGER_ADDR), rand_bits(32));
        end
        ind_check(32'(IND_STATUS_ADDR));
        ind_check(32'(IND_TRIGGER_ADDR));
        ind_write(32'(IND_STATUS_ADDR), rand_bits(32));
        ind_check(32'(IND_STATUS_ADDR));
    endtask

    task automatic test_memory();
        logic [MEM_ADDR_WID-1:0] wr_addrs [NUM_MEM];
        logic [BUS_DATA_WID-1:0] d;
        logic [BUS_DATA_WID-1:0] q;
        for (int i = 0; i < NUM_MEM; i++) begin
            wr_addrs[i] = rand_bits(MEM_ADDR_WID);
            d           = rand_bits(32);
            mem_cmd(wr_addrs[i], 1'b1, d, q);
            mem_model[wr_addrs[i]] = d;
        end
        for (int i = 0; i < NUM_MEM; i++) begin
            mem_cmd(wr_addrs[i], 1'b0, '0, q);
            check_word("MEM_RDATA", mem_model[wr_addrs[i]], q);
        end
    endtask

    task automatic test_address_map();
        logic [BUS_DATA_WID-1:0] q;
        logic [3:0]              region;
        logic [7:0]              ofs;
        for (int r = 0; r < 16; r++) begin
            region = r[3:0];
            if (region != REGION_REG_PROXY && region != REGION_MEM_PROXY) begin
                ofs = rand_bits(8);
                bus_read({region, ofs}, q);
                check_word("o_rd_data", BAD_ADDR_DATA, q);
                bus_write({region, PROXY_ADDR_OFS}, rand_bits(32));
                bus_write({region, MEM_CMD_OFS}, 32'(1) << CMD_WRITE_BIT);
            end
        end
        bus_read({REGION_REG_PROXY, PROXY_ADDR_OFS}, q);
        check_word("PROXY_ADDR", ref_proxy_addr, q);
        bus_read({REGION_MEM_PROXY, MEM_ADDR_OFS}, q);
        check_word("MEM_ADDR", ref_mem_addr, q);
    endtask

    task automatic test_stream();
        logic [STREAM_DATA_WID-1:0] d;
        logic                       l;
        logic                       rdy_seen;
        int                         sent;
        int                         waited;
        sent   = 0;
        waited = 0;
        @(posedge clk);
        d = rand_bits(STREAM_DATA_WID);
        l = rand_bits(1);
        s_tdata  <= d;
        s_tlast  <= l;
        s_tvalid <= 1'b1;
        m_tready <= rand_bits(1);
        while (sent < STREAM_BEATS) begin
            @(negedge clk);
            rdy_seen = s_tready;
            @(posedge clk);
            m_tready <= rand_bits(1);
            if (rdy_seen) begin
                sent_q.push_back({l, d});
                sent++;
                if (sent < STREAM_BEATS) begin
                    d = rand_bits(STREAM_DATA_WID);
                    l = rand_bits(1);
                    s_tdata <= d;
                    s_tlast <= l;
                end else begin
                    s_tvalid <= 1'b0;
                end
            end
        end
        // Drain with the sink always ready
        m_tready <= 1'b1;
        while (sent_q.size() != 0 && waited < BEAT_WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (sent_q.size() != 0) begin
            $display("Stream did not drain, %0d beats still pending", sent_q.size());
            err_other++;
        end
    endtask

    // Output side compare
    always @(negedge clk) begin
        if (!srst && m_tvalid && m_tready) begin
            if (sent_q.size() == 0) begin
                $display("Output beat at %0t with no beat sent", $time);
                err_other++;
            end else begin
                mon_beat = sent_q.pop_front();
                check_beat(mon_beat[STREAM_DATA_WID-1:0], mon_beat[STREAM_DATA_WID],
                           m_tdata, m_tlast);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        wr             = 1'b0;
        rd             = 1'b0;
        addr           = '0;
        wr_data        = '0;
        s_tdata        = '0;
        s_tvalid       = 1'b0;
        s_tlast        = 1'b0;
        m_tready       = 1'b0;
        lfsr_state     = LFSR_SEED;
        err_word       = 0;
        err_beat       = 0;
        err_other      = 0;
        cycle_cnt      = 0;
        ref_trigger    = '0;
        ref_status     = '0;
        ref_proxy_addr = '0;
        ref_mem_addr   = '0;

        @(negedge clk);
        while (srst) begin
            @(negedge clk);
        end
        check_bit("o_ack", 1'b0, ack);
        check_bit("o_m_tvalid", 1'b0, m_tvalid);
        check_bit("o_s_tready", 1'b1, s_tready);

        test_registers();
        test_memory();
        test_address_map();
        test_stream();

        $display("Errors: %0d word, %0d beat, %0d other", err_word, err_beat, err_other);
        if (err_word + err_beat + err_other == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
src/proxy_pkg.sv
src/reg_bus_if.sv
src/bus_decoder.sv
src/reg_proxy.sv
src/mem_proxy.sv
src/mem_ram_sp.sv
src/stream_pipe.sv
src/proxy_test_top.sv
bench/tb_clk_gen.sv
bench/proxy_test_chk.sv
bench/tb_proxy_test.sv

/* src/bus_decoder.sv */
module bus_decoder (
    input  logic                              clk,
    input  logic                              srst,
    input  logic                              i_wr,
    input  logic                              i_rd,
    input  logic [proxy_pkg::BUS_ADDR_WID-1:0] i_addr,
    input  logic [proxy_pkg::BUS_DATA_WID-1:0] i_wr_data,
    output logic [proxy_pkg::BUS_DATA_WID-1:0] o_rd_data,
    output logic                              o_ack,
    reg_bus_if.ctrl                           reg_if,
    reg_bus_if.ctrl                           mem_if
);
    import proxy_pkg::*;

    logic [3:0]              region;
    logic                    sel_reg;
    logic                    sel_mem;
    logic [BUS_DATA_WID-1:0] rd_sel;

    assign region  = i_addr[BUS_ADDR_WID-1 -: 4];
    assign sel_reg = (region == REGION_REG_PROXY);
    assign sel_mem = (region == REGION_MEM_PROXY);

    // Route strobes by region
    assign reg_if.wr      = i_wr & sel_reg;
    assign reg_if.rd      = i_rd & sel_reg;
    assign reg_if.offset  = i_addr[7:0];
    assign reg_if.wr_data = i_wr_data;

    assign mem_if.wr      = i_wr & sel_mem;
    assign mem_if.rd      = i_rd & sel_mem;
    assign mem_if.offset  = i_addr[7:0];
    assign mem_if.wr_data = i_wr_data;

    always_comb begin
        rd_sel = BAD_ADDR_DATA;
        if (sel_reg) begin
            rd_sel = reg_if.rd_data;
        end else if (sel_mem) begin
            rd_sel = mem_if.rd_data;
        end
    end

    // One-cycle ack for every access, mapped or not
    always_ff @(posedge clk) begin
        if (srst) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= i_wr | i_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd) begin
            o_rd_data <= rd_sel;
        end
    end

endmodule

/* src/mem_proxy.sv */
module mem_proxy (
    input  logic                               clk,
    input  logic                               srst,
    reg_bus_if.periph                          bus,
    output logic                               o_mem_en,
    output logic                               o_mem_wr,
    output logic [proxy_pkg::MEM_ADDR_WID-1:0] o_mem_addr,
    output logic [proxy_pkg::BUS_DATA_WID-1:0] o_mem_wdata,
    input  logic [proxy_pkg::BUS_DATA_WID-1:0] i_mem_rdata
);
    import proxy_pkg::*;

    logic [BUS_DATA_WID-1:0] mem_addr;
    logic [BUS_DATA_WID-1:0] mem_wdata;
    logic [BUS_DATA_WID-1:0] mem_cmd;
    logic [BUS_DATA_WID-1:0] mem_rdata;
    logic [BUS_DATA_WID-1:0] status_word;

    // Sequencer stages: RAM cycle, then read capture
    logic access_q;
    logic capture_q;
    logic busy;
    logic cmd_start;

    assign busy      = access_q | capture_q;
    assign cmd_start = bus.wr && (bus.offset == MEM_CMD_OFS) && !busy;

    // ------------------------------------------------------------
    // Command registers and sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            mem_addr  <= '0;
            mem_cmd   <= '0;
            access_q  <= 1'b0;
            capture_q <= 1'b0;
        end else begin
            if (bus.wr && (bus.offset == MEM_ADDR_OFS)) begin
                mem_addr <= bus.wr_data;
            end
            // Commands arriving while busy are dropped
            if (cmd_start) begin
                mem_cmd <= bus.wr_data;
            end
            access_q  <= cmd_start;
            capture_q <= access_q && !mem_cmd[CMD_WRITE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wr && (bus.offset == MEM_WDATA_OFS)) begin
            mem_wdata <= bus.wr_data;
        end
    end

    // RAM data is valid the cycle after the access
    always_ff @(posedge clk) begin
        if (capture_q) begin
            mem_rdata <= i_mem_rdata;
        end
    end

    assign o_mem_en    = access_q;
    assign o_mem_wr    = access_q & mem_cmd[CMD_WRITE_BIT];
    assign o_mem_addr  = mem_addr[MEM_ADDR_WID-1:0];
    assign o_mem_wdata = mem_wdata;

    // ------------------------------------------------------------
    // Host read mux
    // ------------------------------------------------------------
    always_comb begin
        status_word                  = '0;
        status_word[STATUS_BUSY_BIT] = busy;
    end

    always_comb begin
        case (bus.offset)
            MEM_ADDR_OFS:   bus.rd_data = mem_addr;
            MEM_WDATA_OFS:  bus.rd_data = mem_wdata;
            MEM_CMD_OFS:    bus.rd_data = mem_cmd;
            MEM_RDATA_OFS:  bus.rd_data = mem_rdata;
            MEM_STATUS_OFS: bus.rd_data = status_word;
            default:        bus.rd_data = BAD_ADDR_DATA;
        endcase
    end

endmodule

/* src/mem_ram_sp.sv */
module mem_ram_sp (
    input  logic                               clk,
    input  logic                               i_en,
    input  logic                               i_wr,
    input  logic [proxy_pkg::MEM_ADDR_WID-1:0] i_addr,
    input  logic [proxy_pkg::BUS_DATA_WID-1:0] i_wdata,
    output logic [proxy_pkg::BUS_DATA_WID-1:0] o_rdata
);
    import proxy_pkg::*;

    logic [BUS_DATA_WID-1:0] mem [MEM_DEPTH];

    // Read data registered, one cycle latency
    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_wr) begin
                mem[i_addr] <= i_wdata;
            end else begin
                o_rdata <= mem[i_addr];
            end
        end
    end

endmodule

/* src/proxy_pkg.sv */
package proxy_pkg;

    // ------------------------------------------------------------
    // Host bus
    // ------------------------------------------------------------
    localparam int BUS_ADDR_WID = 12;
    localparam int BUS_DATA_WID = 32;

    // Region codes sit in address bits 11..8
    localparam logic [3:0] REGION_REG_PROXY = 4'd1;
    localparam logic [3:0] REGION_MEM_PROXY = 4'd2;

    localparam logic [BUS_DATA_WID-1:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;

    // ------------------------------------------------------------
    // Register proxy map
    // ------------------------------------------------------------
    localparam logic [7:0] PROXY_ADDR_OFS   = 8'h00;
    localparam logic [7:0] PROXY_DATA_OFS   = 8'h04;
    localparam logic [7:0] PROXY_CMD_OFS    = 8'h08;
    localparam logic [7:0] PROXY_STATUS_OFS = 8'h0C;

    // Hidden register block behind the proxy
    localparam logic [7:0] IND_PRE_ADDR     = 8'd0;
    localparam logic [7:0] IND_POST_ADDR    = 8'd1;
    localparam logic [7:0] IND_TRIGGER_ADDR = 8'd2;
    localparam logic [7:0] IND_STATUS_ADDR  = 8'd3;

    // " PRE" and "POST" in ASCII
    localparam logic [BUS_DATA_WID-1:0] INFO_PRE  = 32'h2050_5245;
    localparam logic [BUS_DATA_WID-1:0] INFO_POST = 32'h504F_5354;

    // ------------------------------------------------------------
    // Memory proxy map
    // ------------------------------------------------------------
    localparam logic [7:0] MEM_ADDR_OFS   = 8'h00;
    localparam logic [7:0] MEM_WDATA_OFS  = 8'h04;
    localparam logic [7:0] MEM_CMD_OFS    = 8'h08;
    localparam logic [7:0] MEM_RDATA_OFS  = 8'h0C;
    localparam logic [7:0] MEM_STATUS_OFS = 8'h10;

    localparam int MEM_ADDR_WID = 8;
    localparam int MEM_DEPTH    = 256;

    localparam int STREAM_DATA_WID = 8;

    // Command and status bit positions, shared by both proxies
    localparam int CMD_WRITE_BIT   = 0;
    localparam int STATUS_BUSY_BIT = 0;

endpackage

/* src/proxy_test_top.sv */
module proxy_test_top (
    input  logic                                  clk,
    input  logic                                  srst,
    // Host register bus
    input  logic                                  i_wr,
    input  logic                                  i_rd,
    input  logic [proxy_pkg::BUS_ADDR_WID-1:0]    i_addr,
    input  logic [proxy_pkg::BUS_DATA_WID-1:0]    i_wr_data,
    output logic [proxy_pkg::BUS_DATA_WID-1:0]    o_rd_data,
    output logic                                  o_ack,
    // Stream in
    input  logic [proxy_pkg::STREAM_DATA_WID-1:0] i_s_tdata,
    input  logic                                  i_s_tvalid,
    input  logic                                  i_s_tlast,
    output logic                                  o_s_tready,
    // Stream out
    output logic [proxy_pkg::STREAM_DATA_WID-1:0] o_m_tdata,
    output logic                                  o_m_tvalid,
    output logic                                  o_m_tlast,
    input  logic                                  i_m_tready
);
    import proxy_pkg::*;

    reg_bus_if reg_bus ();
    reg_bus_if mem_bus ();

    logic                    mem_en;
    logic                    mem_wr;
    logic [MEM_ADDR_WID-1:0] mem_addr;
    logic [BUS_DATA_WID-1:0] mem_wdata;
    logic [BUS_DATA_WID-1:0] mem_rdata;

    // ------------------------------------------------------------
    // Register path
    // ------------------------------------------------------------
    bus_decoder i_bus_decoder (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_wr      ( i_wr ),
        .i_rd      ( i_rd ),
        .i_addr    ( i_addr ),
        .i_wr_data ( i_wr_data ),
        .o_rd_data ( o_rd_data ),
        .o_ack     ( o_ack ),
        .reg_if    ( reg_bus ),
        .mem_if    ( mem_bus )
    );

    reg_proxy i_reg_proxy (
        .clk  ( clk ),
        .srst ( srst ),
        .bus  ( reg_bus )
    );

    mem_proxy i_mem_proxy (
        .clk         ( clk ),
        .srst        ( srst ),
        .bus         ( mem_bus ),
        .o_mem_en    ( mem_en ),
        .o_mem_wr    ( mem_wr ),
        .o_mem_addr  ( mem_addr ),
        .o_mem_wdata ( mem_wdata ),
        .i_mem_rdata ( mem_rdata )
    );

    mem_ram_sp i_mem_ram_sp (
        .clk     ( clk ),
        .i_en    ( mem_en ),
        .i_wr    ( mem_wr ),
        .i_addr  ( mem_addr ),
        .i_wdata ( mem_wdata ),
        .o_rdata ( mem_rdata )
    );

    // ------------------------------------------------------------
    // Stream pass-through
    // ------------------------------------------------------------
    stream_pipe i_stream_pipe (
        .clk      ( clk ),
        .srst     ( srst ),
        .i_tdata  ( i_s_tdata ),
        .i_tvalid ( i_s_tvalid ),
        .i_tlast  ( i_s_tlast ),
        .o_tready ( o_s_tready ),
        .o_tdata  ( o_m_tdata ),
        .o_tvalid ( o_m_tvalid ),
        .o_tlast  ( o_m_tlast ),
        .i_tready ( i_m_tready )
    );

endmodule

/* src/reg_bus_if.sv */
interface reg_bus_if;
    import proxy_pkg::*;

    // Strobes already qualified by region
    logic                    wr;
    logic                    rd;
    logic [7:0]              offset;
    logic [BUS_DATA_WID-1:0] wr_data;
    // Combinational read data from the peripheral
    logic [BUS_DATA_WID-1:0] rd_data;

    modport ctrl (
        output wr,
        output rd,
        output offset,
        output wr_data,
        input  rd_data
    );

    modport periph (
        input  wr,
        input  rd,
        input  offset,
        input  wr_data,
        output rd_data
    );

endinterface

/* src/reg_proxy.sv */
module reg_proxy (
    input  logic      clk,
    input  logic      srst,
    reg_bus_if.periph bus
);
    import proxy_pkg::*;

    logic [BUS_DATA_WID-1:0] proxy_addr;
    logic [BUS_DATA_WID-1:0] proxy_data;
    logic [BUS_DATA_WID-1:0] proxy_cmd;
    logic                    busy;
    logic                    cmd_start;

    // Hidden register block
    logic [BUS_DATA_WID-1:0] trigger;
    logic [BUS_DATA_WID-1:0] ind_status;
    logic                    ind_addr_ok;
    logic                    trigger_wr;
    logic [BUS_DATA_WID-1:0] ind_rd_data;
    logic [BUS_DATA_WID-1:0] status_word;

    assign cmd_start   = bus.wr && (bus.offset == PROXY_CMD_OFS) && !busy;
    assign ind_addr_ok = (proxy_addr[BUS_DATA_WID-1:8] == '0);
    assign trigger_wr  = busy && proxy_cmd[CMD_WRITE_BIT] && ind_addr_ok &&
                         (proxy_addr[7:0] == IND_TRIGGER_ADDR);

    // ------------------------------------------------------------
    // Command registers and the one-cycle indirect access
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            proxy_addr <= '0;
            proxy_cmd  <= '0;
            busy       <= 1'b0;
            trigger    <= '0;
            ind_status <= '0;
        end else begin
            if (bus.wr && (bus.offset == PROXY_ADDR_OFS)) begin
                proxy_addr <= bus.wr_data;
            end
            if (cmd_start) begin
                proxy_cmd <= bus.wr_data;
            end
            busy <= cmd_start;
            // Status follows every trigger write
            if (trigger_wr) begin
                trigger    <= proxy_data;
                ind_status <= proxy_data;
            end
        end
    end

    // Indirect read result lands in the data register
    always_ff @(posedge clk) begin
        if (busy && !proxy_cmd[CMD_WRITE_BIT]) begin
            proxy_data <= ind_rd_data;
        end else if (bus.wr && (bus.offset == PROXY_DATA_OFS)) begin
            proxy_data <= bus.wr_data;
        end
    end

    always_comb begin
        ind_rd_data = BAD_ADDR_DATA;
        if (ind_addr_ok) begin
            case (proxy_addr[7:0])
                IND_PRE_ADDR:     ind_rd_data = INFO_PRE;
                IND_POST_ADDR:    ind_rd_data = INFO_POST;
                IND_TRIGGER_ADDR: ind_rd_data = trigger;
                IND_STATUS_ADDR:  ind_rd_data = ind_status;
                default:          ind_rd_data = BAD_ADDR_DATA;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Host read mux
    // ------------------------------------------------------------
    always_comb begin
        status_word                  = '0;
        status_word[STATUS_BUSY_BIT] = busy;
    end

    always_comb begin
        case (bus.offset)
            PROXY_ADDR_OFS:   bus.rd_data = proxy_addr;
            PROXY_DATA_OFS:   bus.rd_data = proxy_data;
            PROXY_CMD_OFS:    bus.rd_data = proxy_cmd;
            PROXY_STATUS_OFS: bus.rd_data = status_word;
            default:          bus.rd_data = BAD_ADDR_DATA;
        endcase
    end

endmodule

/* src/stream_pipe.sv */
module stream_pipe (
    input  logic                                  clk,
    input  logic                                  srst,
    input  logic [proxy_pkg::STREAM_DATA_WID-1:0] i_tdata,
    input  logic                                  i_tvalid,
    input  logic                                  i_tlast,
    output logic                                  o_tready,
    output logic [proxy_pkg::STREAM_DATA_WID-1:0] o_tdata,
    output logic                                  o_tvalid,
    output logic                                  o_tlast,
    input  logic                                  i_tready
);
    import proxy_pkg::*;

    logic                       main_valid;
    logic [STREAM_DATA_WID-1:0] main_data;
    logic                       main_last;
    logic                       skid_valid;
    logic [STREAM_DATA_WID-1:0] skid_data;
    logic                       skid_last;
    logic                       in_xfer;
    logic                       main_free;

    // Ready comes straight from the skid flop
    assign o_tready  = !skid_valid;
    assign in_xfer   = i_tvalid && o_tready;
    assign main_free = !main_valid || i_tready;

    always_ff @(posedge clk) begin
        if (srst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_free) begin
            // Skid entry drains first to keep order
            main_valid <= skid_valid || in_xfer;
            skid_valid <= 1'b0;
        end else if (in_xfer) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (skid_valid) begin
                main_data <= skid_data;
                main_last <= skid_last;
            end else if (in_xfer) begin
                main_data <= i_tdata;
                main_last <= i_tlast;
            end
        end else if (in_xfer) begin
            skid_data <= i_tdata;
            skid_last <= i_tlast;
        end
    end

    assign o_tvalid = main_valid;
    assign o_tdata  = main_data;
    assign o_tlast  = main_last;

endmodule
